// ==== src/des_types_pkg.sv ====
// DES widths, data types and pipeline structs, imported by the RTL and the testbench
package des_types_pkg;

    localparam int BLOCK_W      = 64;
    localparam int HALF_W       = 32;
    localparam int KEY_W        = 64;
    localparam int CD_W         = 56;
    localparam int CD_HALF_W    = 28;
    localparam int SUBKEY_W     = 48;
    localparam int NUM_ROUNDS   = 16;
    localparam int NUM_SBOX     = 8;
    localparam int SBOX_IN_W    = 6;
    localparam int SBOX_OUT_W   = 4;
    // request accepted to response visible
    localparam int PIPE_LATENCY = 18;

    // DES bit 1 sits at the msb
    typedef logic [BLOCK_W-1:0]  block_t;
    typedef logic [HALF_W-1:0]   half_t;
    typedef logic [KEY_W-1:0]    key_t;
    // C in the upper half, D in the lower
    typedef logic [CD_W-1:0]     cd_t;
    typedef logic [SUBKEY_W-1:0] subkey_t;

    typedef struct packed {
        logic   valid;
        block_t block;
        key_t   key;
    } des_req_t;

    typedef struct packed {
        logic   valid;
        block_t block;
    } des_rsp_t;

    // per-stage state, key halves travel with their block
    typedef struct packed {
        logic  valid;
        half_t l;
        half_t r;
        cd_t   cd;
    } round_state_t;

endpackage

// ==== src/des_tables_pkg.sv ====
// DES permutation tables, S-boxes, rotation schedule and table permute helpers
package des_tables_pkg;

    // entries are 1-based DES bit positions, bit 1 is the msb
    localparam int IP_TABLE [64] = '{
        58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
    };

    localparam int FP_TABLE [64] = '{
        40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41, 9, 49, 17, 57, 25
    };

    // parity bits 8, 16 .. 64 are dropped here
    localparam int PC1_TABLE [56] = '{
        57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
        10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
        14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4
    };

    localparam int PC2_TABLE [48] = '{
        14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10,
        23, 19, 12, 4, 26, 8, 16, 7, 27, 20, 13, 2,
        41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
        44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
    };

    localparam int E_TABLE [48] = '{
        32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9, 8, 9, 10, 11,
        12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
        22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1
    };

    localparam int P_TABLE [32] = '{
        16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
        2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25
    };

    // index is row * 16 + column
    localparam logic [3:0] SBOX_TABLE [8][64] = '{
        '{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7,
          0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8,
          4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0,
          15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13},
        '{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10,
          3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5,
          0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15,
          13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9},
        '{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8,
          13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1,
          13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7,
          1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12},
        '{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15,
          13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9,
          10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4,
          3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14},
        '{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9,
          14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6,
          4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14,
          11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3},
        '{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11,
          10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8,
          9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6,
          4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13},
        '{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1,
          13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6,
          1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2,
          6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12},
        '{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7,
          1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2,
          7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8,
          2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}
    };

    localparam int ROT_SCHEDULE [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

    // output bit i (from the msb) takes input bit tbl[i]
    function automatic logic [63:0] permute_64to64(input logic [63:0] din, input int tbl [64]);
        logic [63:0] dout;
        for (int i = 0; i < 64; i++)
        begin
            dout[63 - i] = din[64 - tbl[i]];
        end
        return dout;
    endfunction

    function automatic logic [55:0] permute_64to56(input logic [63:0] din, input int tbl [56]);
        logic [55:0] dout;
        for (int i = 0; i < 56; i++)
        begin
            dout[55 - i] = din[64 - tbl[i]];
        end
        return dout;
    endfunction

    function automatic logic [47:0] permute_56to48(input logic [55:0] din, input int tbl [48]);
        logic [47:0] dout;
        for (int i = 0; i < 48; i++)
        begin
            dout[47 - i] = din[56 - tbl[i]];
        end
        return dout;
    endfunction

    function automatic logic [47:0] permute_32to48(input logic [31:0] din, input int tbl [48]);
        logic [47:0] dout;
        for (int i = 0; i < 48; i++)
        begin
            dout[47 - i] = din[32 - tbl[i]];
        end
        return dout;
    endfunction

    function automatic logic [31:0] permute_32to32(input logic [31:0] din, input int tbl [32]);
        logic [31:0] dout;
        for (int i = 0; i < 32; i++)
        begin
            dout[31 - i] = din[32 - tbl[i]];
        end
        return dout;
    endfunction

endpackage

// ==== src/des_feistel.sv ====
// combinational DES round function f(R, K), instantiated once per pipeline round
`timescale 1ns/1ps

module des_feistel
    import des_types_pkg::*;
    import des_tables_pkg::*;
(
    input  half_t   r,
    input  subkey_t subkey,
    output half_t   f_out
);

    subkey_t mixed;
    half_t   sbox_out;

    // expansion, then key mix
    assign mixed = permute_32to48(r, E_TABLE) ^ subkey;

    // S1 takes the top six bits
    for (genvar g = 0; g < NUM_SBOX; g++)
    begin : g_sbox
        logic [SBOX_IN_W-1:0] grp;

        assign grp = mixed[SUBKEY_W - 1 - g * SBOX_IN_W -: SBOX_IN_W];

        // row from outer bits, column from inner four
        assign sbox_out[HALF_W - 1 - g * SBOX_OUT_W -: SBOX_OUT_W] =
            SBOX_TABLE[g][{grp[SBOX_IN_W-1], grp[0], grp[SBOX_IN_W-2:1]}];
    end

    assign f_out = permute_32to32(sbox_out, P_TABLE);

endmodule

// ==== src/des_round.sv ====
// one registered DES round, carrying its own rotating C/D key halves with the block
`timescale 1ns/1ps

module des_round
    import des_types_pkg::*;
    import des_tables_pkg::*;
#(
    parameter int ROUND_IDX = 1
)
(
    input  logic         clk,
    input  logic         rst,
    input  round_state_t state_in,
    output round_state_t state_out
);

    logic [CD_HALF_W-1:0] c_in;
    logic [CD_HALF_W-1:0] d_in;
    logic [CD_HALF_W-1:0] c_rot;
    logic [CD_HALF_W-1:0] d_rot;
    cd_t                  cd_rot;
    subkey_t              subkey;
    half_t                f_out;

    assign c_in = state_in.cd[CD_W-1 -: CD_HALF_W];
    assign d_in = state_in.cd[CD_HALF_W-1:0];

    // left rotate by one or two places depending on the round
    assign c_rot = (c_in << ROT_SCHEDULE[ROUND_IDX-1])
                 | (c_in >> (CD_HALF_W - ROT_SCHEDULE[ROUND_IDX-1]));
    assign d_rot = (d_in << ROT_SCHEDULE[ROUND_IDX-1])
                 | (d_in >> (CD_HALF_W - ROT_SCHEDULE[ROUND_IDX-1]));

    assign cd_rot = {c_rot, d_rot};
    assign subkey = permute_56to48(cd_rot, PC2_TABLE);

    des_feistel u_feistel (
        .r      (state_in.r),
        .subkey (subkey),
        .f_out  (f_out)
    );

    always_ff @(posedge clk)
    begin
        state_out.l  <= state_in.r;
        state_out.r  <= state_in.l ^ f_out;
        state_out.cd <= cd_rot;
        if (rst)
        begin
            state_out.valid <= 1'b0;
        end
        else
        begin
            state_out.valid <= state_in.valid;
        end
    end

endmodule

// ==== src/des_pipeline_top.sv ====
// fully pipelined DES encryption core, one block and key per cycle, 18 cycle latency
`timescale 1ns/1ps

module des_pipeline_top
    import des_types_pkg::*;
    import des_tables_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  des_req_t req,
    output des_rsp_t rsp
);

    des_req_t     req_q;
    block_t       ip_block;
    round_state_t stage0_q;
    round_state_t stage [NUM_ROUNDS+1];
    block_t       fp_block;

    // capture the request as it arrives
    always_ff @(posedge clk)
    begin
        req_q.block <= req.block;
        req_q.key   <= req.key;
        if (rst)
        begin
            req_q.valid <= 1'b0;
        end
        else
        begin
            req_q.valid <= req.valid;
        end
    end

    assign ip_block = permute_64to64(req_q.block, IP_TABLE);

    // input stage, IP on the block and PC-1 on the key
    always_ff @(posedge clk)
    begin
        stage0_q.l  <= ip_block[BLOCK_W-1 -: HALF_W];
        stage0_q.r  <= ip_block[HALF_W-1:0];
        stage0_q.cd <= permute_64to56(req_q.key, PC1_TABLE);
        if (rst)
        begin
            stage0_q.valid <= 1'b0;
        end
        else
        begin
            stage0_q.valid <= req_q.valid;
        end
    end

    assign stage[0] = stage0_q;

    for (genvar g = 1; g <= NUM_ROUNDS; g++)
    begin : g_round
        des_round #(
            .ROUND_IDX (g)
        ) u_round (
            .clk       (clk),
            .rst       (rst),
            .state_in  (stage[g-1]),
            .state_out (stage[g])
        );
    end

    // final swap R16 L16 before FP
    assign fp_block = permute_64to64({stage[NUM_ROUNDS].r, stage[NUM_ROUNDS].l}, FP_TABLE);

    always_ff @(posedge clk)
    begin
        rsp.block <= fp_block;
        if (rst)
        begin
            rsp.valid <= 1'b0;
        end
        else
        begin
            rsp.valid <= stage[NUM_ROUNDS].valid;
        end
    end

endmodule

// ==== include/des_model.svh ====
// behavioural DES encryption functions, included by the testbench as its reference model
`ifndef DES_MODEL_SVH
`define DES_MODEL_SVH

// round function, bit by bit from the tables
function automatic des_types_pkg::half_t des_model_f(
    input des_types_pkg::half_t   r,
    input des_types_pkg::subkey_t k
);
    logic [47:0] x;
    logic [31:0] s;
    logic [5:0]  grp;
    logic [1:0]  row;
    logic [3:0]  col;
    x = des_tables_pkg::permute_32to48(r, des_tables_pkg::E_TABLE) ^ k;
    for (int i = 0; i < 8; i++)
    begin
        grp = x[47 - 6 * i -: 6];
        row = {grp[5], grp[0]};
        col = grp[4:1];
        s[31 - 4 * i -: 4] = des_tables_pkg::SBOX_TABLE[i][16 * row + col];
    end
    return des_tables_pkg::permute_32to32(s, des_tables_pkg::P_TABLE);
endfunction

function automatic des_types_pkg::block_t des_encrypt_model(
    input des_types_pkg::block_t block,
    input des_types_pkg::key_t   key
);
    logic [63:0] ip;
    logic [55:0] cd;
    logic [31:0] l;
    logic [31:0] r;
    logic [31:0] r_next;
    logic [27:0] c;
    logic [27:0] d;
    logic [47:0] k;
    ip = des_tables_pkg::permute_64to64(block, des_tables_pkg::IP_TABLE);
    l  = ip[63:32];
    r  = ip[31:0];
    cd = des_tables_pkg::permute_64to56(key, des_tables_pkg::PC1_TABLE);
    c  = cd[55:28];
    d  = cd[27:0];
    for (int rnd = 0; rnd < 16; rnd++)
    begin
        // one place at a time
        for (int n = 0; n < des_tables_pkg::ROT_SCHEDULE[rnd]; n++)
        begin
            c = {c[26:0], c[27]};
            d = {d[26:0], d[27]};
        end
        k      = des_tables_pkg::permute_56to48({c, d}, des_tables_pkg::PC2_TABLE);
        r_next = l ^ des_model_f(r, k);
        l      = r;
        r      = r_next;
    end
    return des_tables_pkg::permute_64to64({r, l}, des_tables_pkg::FP_TABLE);
endfunction

`endif

// ==== test/des_tb.sv ====
// directed testbench for the pipelined DES core, checks every response against the reference model
`timescale 1ns/1ps

module des_tb
    import des_types_pkg::*;
();

`include "des_model.svh"

    localparam block_t KNOWN_PT       = 64'h0123_4567_89AB_CDEF;
    localparam key_t   KNOWN_KEY      = 64'h1334_5779_9BBC_DFF1;
    localparam block_t KNOWN_CT       = 64'h85E8_1354_0F0A_B405;
    localparam int     STREAM_LEN     = 200;
    localparam int     BUBBLE_LEN     = 100;
    localparam int     FLIGHT_LEN     = 12;
    localparam int     AFTER_RST_LEN  = 20;
    // tests need about 500 cycles, so twice that is plenty
    localparam int     TIMEOUT_CYCLES = 1000;

    logic     clk = 1'b0;
    logic     rst;
    des_req_t req;
    des_rsp_t rsp;

    // expected ciphertexts in request order
    block_t exp_q [$];
    // expected rsp.valid, from the falling edge before acceptance to the response
    logic   valid_line [PIPE_LATENCY+1] = '{default: 1'b0};
    int     cycles = 0;
    int     checks = 0;
    int     errors = 0;

    des_pipeline_top u_dut (
        .clk (clk),
        .rst (rst),
        .req (req),
        .rsp (rsp)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_block(input string name, input block_t got, input block_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_valid(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk)
    begin
        block_t exp_block;
        check_valid("rsp.valid", rsp.valid, valid_line[PIPE_LATENCY]);
        if (rsp.valid === 1'b1)
        begin
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("error at %0t: a response came out with no request outstanding", $time);
            end
            else
            begin
                exp_block = exp_q.pop_front();
                check_block("rsp.block", rsp.block, exp_block);
            end
        end
        for (int i = PIPE_LATENCY; i > 0; i--)
        begin
            valid_line[i] = valid_line[i-1];
        end
        valid_line[0] = (rst === 1'b1) ? 1'b0 : req.valid;
        // reset drops everything in flight
        if (rst === 1'b1)
        begin
            exp_q.delete();
            for (int i = 0; i <= PIPE_LATENCY; i++)
            begin
                valid_line[i] = 1'b0;
            end
        end
    end

    function automatic logic [63:0] random_word64();
        return {$urandom, $urandom};
    endfunction

    task automatic send_req(input block_t blk, input key_t k);
        @(posedge clk);
        req.valid <= 1'b1;
        req.block <= blk;
        req.key   <= k;
        exp_q.push_back(des_encrypt_model(blk, k));
    endtask

    // idle cycle with junk data that must be ignored
    task automatic send_idle();
        @(posedge clk);
        req.valid <= 1'b0;
        req.block <= random_word64();
        req.key   <= random_word64();
    endtask

    task automatic drain();
        while (exp_q.size() != 0)
        begin
            @(negedge clk);
        end
    endtask

    task automatic report_test(input string name, input int err_mark);
        if (errors == err_mark)
        begin
            $display("test %s passed", name);
        end
        else
        begin
            $display("test %s failed with %0d errors", name, errors - err_mark);
        end
    endtask

    task automatic test_known_vector(output bit model_ok);
        block_t model_ct;
        model_ct = des_encrypt_model(KNOWN_PT, KNOWN_KEY);
        check_block("model ciphertext", model_ct, KNOWN_CT);
        model_ok = (model_ct === KNOWN_CT);
        if (model_ok)
        begin
            send_req(KNOWN_PT, KNOWN_KEY);
            send_idle();
            drain();
        end
    endtask

    task automatic test_latency();
        send_req(random_word64(), random_word64());
        send_idle();
        // cycle 0 is the falling edge right after the accepting edge
        for (int j = 0; j <= PIPE_LATENCY + 2; j++)
        begin
            @(negedge clk);
            check_valid("rsp.valid latency", rsp.valid, j == PIPE_LATENCY);
        end
        drain();
    endtask

    task automatic test_stream();
        for (int i = 0; i < STREAM_LEN; i++)
        begin
            send_req(random_word64(), random_word64());
        end
        send_idle();
        drain();
    endtask

    task automatic test_bubbles();
        for (int i = 0; i < BUBBLE_LEN; i++)
        begin
            if ($urandom % 2 == 1)
            begin
                send_req(random_word64(), random_word64());
            end
            else
            begin
                send_idle();
            end
        end
        send_idle();
        drain();
    endtask

    task automatic test_reset_flight();
        for (int i = 0; i < FLIGHT_LEN; i++)
        begin
            send_req(random_word64(), random_word64());
        end
        @(posedge clk);
        rst       <= 1'b1;
        req.valid <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // nothing may come out before new requests
        for (int i = 0; i < PIPE_LATENCY + 2; i++)
        begin
            @(negedge clk);
            check_valid("rsp.valid after reset", rsp.valid, 1'b0);
        end
        for (int i = 0; i < AFTER_RST_LEN; i++)
        begin
            send_req(random_word64(), random_word64());
        end
        send_idle();
        drain();
    endtask

    initial
    begin
        bit model_ok;
        int err_mark;
        rst = 1'b1;
        req = '0;
        void'($urandom(32'h49a9_dc1b));
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        err_mark = errors;
        test_known_vector(model_ok);
        report_test("known vector", err_mark);
        if (model_ok)
        begin
            err_mark = errors;
            test_latency();
            report_test("latency", err_mark);
            err_mark = errors;
            test_stream();
            report_test("stream", err_mark);
            err_mark = errors;
            test_bubbles();
            report_test("bubbles", err_mark);
            err_mark = errors;
            test_reset_flight();
            report_test("reset", err_mark);
        end
        else
        begin
            $display("the reference model disagrees with the known vector, DUT tests skipped");
        end

        $display("summary: %0d checks, %0d errors, %0d cycles", checks, errors, cycles);
        if (errors == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
src/des_types_pkg.sv
src/des_tables_pkg.sv
src/des_feistel.sv
src/des_round.sv
src/des_pipeline_top.sv
test/des_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0 -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
TOP        := des_tb
RTL_TOP    := des_pipeline_top
FILELIST   := sim.f
RTL_SRCS   := src/des_types_pkg.sv src/des_tables_pkg.sv src/des_feistel.sv \
              src/des_round.sv src/des_pipeline_top.sv
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
